// File: source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // --------------------
  typedef logic [31:0] data_t;
  typedef logic [31:0] inst_t;
  typedef logic [31:0] pc_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [2:0]  alu_op_t;
  typedef logic [1:0]  mem_op_t;
  typedef logic [1:0]  fwd_sel_t;

  localparam int NUM_REGS       = 32;
  localparam int DMEM_ADDR_BITS = 8;
  localparam int DMEM_WORDS     = 1 << DMEM_ADDR_BITS;  // 256 words.

  // --------------------
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_ADDI  = 6'h08;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] OP_J     = 6'h02;

  localparam logic [5:0] FN_ADD = 6'h20;
  localparam logic [5:0] FN_SUB = 6'h22;
  localparam logic [5:0] FN_AND = 6'h24;
  localparam logic [5:0] FN_OR  = 6'h25;
  localparam logic [5:0] FN_SLT = 6'h2a;

  localparam inst_t NOP_INST = 32'h0000_0000;  // r-type with funct 0, decodes to no write.

  // --------------------
  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_SLT = 3'd4;

  localparam mem_op_t MEM_NONE  = 2'd0;
  localparam mem_op_t MEM_LOAD  = 2'd1;
  localparam mem_op_t MEM_STORE = 2'd2;

  localparam fwd_sel_t FWD_NONE = 2'd0;
  localparam fwd_sel_t FWD_MEM  = 2'd1;
  localparam fwd_sel_t FWD_WB   = 2'd2;

endpackage

`default_nettype wire

// File: source/pipeline_regs.sv
`timescale 1ns/1ps
`default_nettype none

module if_id_register (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           stall,
  input  logic           flush,
  input  cpu_pkg::inst_t inst_in,
  input  cpu_pkg::pc_t   pc_plus4_in,
  output cpu_pkg::inst_t inst_out,
  output cpu_pkg::pc_t   pc_plus4_out
);

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      inst_out     <= cpu_pkg::NOP_INST;
      pc_plus4_out <= '0;
    end else if (!stall) begin
      inst_out     <= inst_in;
      pc_plus4_out <= pc_plus4_in;
    end
  end

endmodule

module id_ex_register (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              stall,
  input  logic              flush,
  input  cpu_pkg::reg_idx_t rs_in, rt_in, rd_in,
  input  cpu_pkg::data_t    read_data_1_in, read_data_2_in, immediate_in,
  input  cpu_pkg::pc_t      target_in,
  input  logic              reg_dst_in, alu_src_in, reg_write_in, beq_in, bne_in, jump_in,
  input  cpu_pkg::alu_op_t  alu_op_in,
  input  cpu_pkg::mem_op_t  mem_op_in,
  output cpu_pkg::reg_idx_t rs_out, rt_out, rd_out,
  output cpu_pkg::data_t    read_data_1_out, read_data_2_out, immediate_out,
  output cpu_pkg::pc_t      target_out,
  output logic              reg_dst_out, alu_src_out, reg_write_out, beq_out, bne_out, jump_out,
  output cpu_pkg::alu_op_t  alu_op_out,
  output cpu_pkg::mem_op_t  mem_op_out
);

  always_ff @(posedge clk) begin
    if (!rst_n || stall || flush) begin  // bubble.
      {rs_out, rt_out, rd_out} <= '0;
      {read_data_1_out, read_data_2_out, immediate_out, target_out} <= '0;
      {reg_dst_out, alu_src_out, reg_write_out, beq_out, bne_out, jump_out} <= '0;
      {alu_op_out, mem_op_out} <= '0;
    end else begin
      rs_out          <= rs_in;
      rt_out          <= rt_in;
      rd_out          <= rd_in;
      read_data_1_out <= read_data_1_in;
      read_data_2_out <= read_data_2_in;
      immediate_out   <= immediate_in;
      target_out      <= target_in;
      reg_dst_out     <= reg_dst_in;
      alu_src_out     <= alu_src_in;
      reg_write_out   <= reg_write_in;
      beq_out         <= beq_in;
      bne_out         <= bne_in;
      jump_out        <= jump_in;
      alu_op_out      <= alu_op_in;
      mem_op_out      <= mem_op_in;
    end
  end

endmodule

module ex_mem_register (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush,
  input  cpu_pkg::data_t    alu_result_in, store_data_in,
  input  cpu_pkg::pc_t      target_in,
  input  cpu_pkg::reg_idx_t dst_reg_in,
  input  logic              compare_in, beq_in, bne_in, jump_in, reg_write_in,
  input  cpu_pkg::mem_op_t  mem_op_in,
  output cpu_pkg::data_t    alu_result_out, store_data_out,
  output cpu_pkg::pc_t      target_out,
  output cpu_pkg::reg_idx_t dst_reg_out,
  output logic              compare_out, beq_out, bne_out, jump_out, reg_write_out,
  output cpu_pkg::mem_op_t  mem_op_out,
  output logic              redirect
);

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      {alu_result_out, store_data_out, target_out, dst_reg_out} <= '0;
      {compare_out, beq_out, bne_out, jump_out, reg_write_out, mem_op_out} <= '0;
    end else begin
      alu_result_out <= alu_result_in;
      store_data_out <= store_data_in;
      target_out     <= target_in;
      dst_reg_out    <= dst_reg_in;
      compare_out    <= compare_in;
      beq_out        <= beq_in;
      bne_out        <= bne_in;
      jump_out       <= jump_in;
      reg_write_out  <= reg_write_in;
      mem_op_out     <= mem_op_in;
    end
  end

  // branch resolves here, fetch is redirected at the end of this cycle.
  assign redirect = (beq_out && compare_out) || (bne_out && !compare_out) || jump_out;

  // the decoder raises at most one of these per instruction.
  a_one_redirect_kind: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({beq_out, bne_out, jump_out}));

endmodule

module mem_wb_register (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              mem_to_reg_in, reg_write_in,
  input  cpu_pkg::data_t    ram_read_data_in, alu_result_in,
  input  cpu_pkg::reg_idx_t dst_reg_in,
  output logic              mem_to_reg_out, reg_write_out,
  output cpu_pkg::data_t    ram_read_data_out, alu_result_out,
  output cpu_pkg::reg_idx_t dst_reg_out,
  output cpu_pkg::data_t    write_data
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      {mem_to_reg_out, reg_write_out, ram_read_data_out, alu_result_out, dst_reg_out} <= '0;
    end else begin
      mem_to_reg_out    <= mem_to_reg_in;
      reg_write_out     <= reg_write_in;
      ram_read_data_out <= ram_read_data_in;
      alu_result_out    <= alu_result_in;
      dst_reg_out       <= dst_reg_in;
    end
  end

  assign write_data = mem_to_reg_out ? ram_read_data_out : alu_result_out;

endmodule

`default_nettype wire

// File: source/control_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module control_decoder (
  input  cpu_pkg::inst_t    inst,
  output cpu_pkg::reg_idx_t rs,
  output cpu_pkg::reg_idx_t rt,
  output cpu_pkg::reg_idx_t rd,
  output cpu_pkg::data_t    immediate,
  output cpu_pkg::pc_t      target,
  output logic              reg_dst,
  output logic              alu_src,
  output logic              reg_write,
  output logic              beq,
  output logic              bne,
  output logic              jump,
  output cpu_pkg::alu_op_t  alu_op,
  output cpu_pkg::mem_op_t  mem_op
);

  logic [5:0] opcode;
  logic [5:0] funct;
  logic       writes;

  assign opcode    = inst[31:26];
  assign funct     = inst[5:0];
  assign rs        = inst[25:21];
  assign rt        = inst[20:16];
  assign rd        = inst[15:11];
  assign immediate = {{16{inst[15]}}, inst[15:0]};
  assign target    = {4'b0000, inst[25:0], 2'b00};  // absolute word target.

  always_comb begin
    reg_dst = 1'b0;
    alu_src = 1'b0;
    writes  = 1'b0;
    beq     = 1'b0;
    bne     = 1'b0;
    jump    = 1'b0;
    alu_op  = cpu_pkg::ALU_ADD;
    mem_op  = cpu_pkg::MEM_NONE;
    case (opcode)
      cpu_pkg::OP_RTYPE: begin
        reg_dst = 1'b1;
        writes  = 1'b1;
        case (funct)
          cpu_pkg::FN_ADD: alu_op = cpu_pkg::ALU_ADD;
          cpu_pkg::FN_SUB: alu_op = cpu_pkg::ALU_SUB;
          cpu_pkg::FN_AND: alu_op = cpu_pkg::ALU_AND;
          cpu_pkg::FN_OR:  alu_op = cpu_pkg::ALU_OR;
          cpu_pkg::FN_SLT: alu_op = cpu_pkg::ALU_SLT;
          default:         writes = 1'b0;  // unknown funct, no-op.
        endcase
      end
      cpu_pkg::OP_ADDI: begin
        alu_src = 1'b1;
        writes  = 1'b1;
      end
      cpu_pkg::OP_LW: begin
        alu_src = 1'b1;
        writes  = 1'b1;
        mem_op  = cpu_pkg::MEM_LOAD;
      end
      cpu_pkg::OP_SW: begin
        alu_src = 1'b1;
        mem_op  = cpu_pkg::MEM_STORE;
      end
      cpu_pkg::OP_BEQ: beq  = 1'b1;
      cpu_pkg::OP_BNE: bne  = 1'b1;
      cpu_pkg::OP_J:   jump = 1'b1;
      default: ;
    endcase
  end

  // register 0 is never written.
  assign reg_write = writes && ((reg_dst ? rd : rt) != '0);

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic              clk,
  input  logic              rst_n,
  input  cpu_pkg::reg_idx_t read_reg_1,
  input  cpu_pkg::reg_idx_t read_reg_2,
  input  cpu_pkg::reg_idx_t write_reg,
  input  logic              write_en,
  input  cpu_pkg::data_t    write_data,
  output cpu_pkg::data_t    read_data_1,
  output cpu_pkg::data_t    read_data_2
);

  cpu_pkg::data_t regs [cpu_pkg::NUM_REGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[write_reg] <= write_data;
    end
  end

  function automatic cpu_pkg::data_t read_port(input cpu_pkg::reg_idx_t idx);
    if (idx == '0) return '0;
    if (write_en && write_reg == idx) return write_data;  // write-through.
    return regs[idx];
  endfunction

  always_comb begin
    read_data_1 = read_port(read_reg_1);
    read_data_2 = read_port(read_reg_2);
  end

  // zero-destination writes are dropped in decode and must never reach write-back.
  a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
    !(write_en && write_reg == '0));

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  cpu_pkg::alu_op_t op,
  input  cpu_pkg::data_t   a,
  input  cpu_pkg::data_t   b,
  output cpu_pkg::data_t   result,
  output logic             equal
);

  always_comb begin
    case (op)
      cpu_pkg::ALU_ADD: result = a + b;
      cpu_pkg::ALU_SUB: result = a - b;
      cpu_pkg::ALU_AND: result = a & b;
      cpu_pkg::ALU_OR:  result = a | b;
      cpu_pkg::ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
      default:          result = a + b;
    endcase
  end

  assign equal = (a == b);  // branch compare.

endmodule

`default_nettype wire

// File: source/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  cpu_pkg::reg_idx_t id_rs,
  input  cpu_pkg::reg_idx_t id_rt,
  input  cpu_pkg::reg_idx_t ex_rs,
  input  cpu_pkg::reg_idx_t ex_rt,
  input  cpu_pkg::reg_idx_t mem_dst,
  input  cpu_pkg::reg_idx_t wb_dst,
  input  logic              mem_reg_write,
  input  logic              wb_reg_write,
  input  logic              ex_load,
  input  logic              redirect,
  output logic              stall,
  output logic              flush,
  output cpu_pkg::fwd_sel_t fwd_a,
  output cpu_pkg::fwd_sel_t fwd_b
);

  logic load_use;

  // the younger producer wins.
  function automatic cpu_pkg::fwd_sel_t pick(input cpu_pkg::reg_idx_t src);
    if (mem_reg_write && mem_dst == src) return cpu_pkg::FWD_MEM;
    if (wb_reg_write && wb_dst == src) return cpu_pkg::FWD_WB;
    return cpu_pkg::FWD_NONE;
  endfunction

  // a load writes rt, so ex_rt is its destination.
  assign load_use = ex_load && (ex_rt == id_rs || ex_rt == id_rt);

  always_comb begin
    fwd_a = pick(ex_rs);
    fwd_b = pick(ex_rt);
    flush = redirect;
    stall = load_use && !redirect;  // flush wins.
  end

  always_comb begin
    assert (!(stall && flush)) else $error("stall and flush high together.");
  end

endmodule

`default_nettype wire

// File: source/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram (
  input  logic           clk,
  input  cpu_pkg::data_t addr,
  input  logic           write_en,
  input  cpu_pkg::data_t write_data,
  output cpu_pkg::data_t read_data
);

  cpu_pkg::data_t mem [cpu_pkg::DMEM_WORDS];

  logic [cpu_pkg::DMEM_ADDR_BITS-1:0] word;

  assign word = addr[cpu_pkg::DMEM_ADDR_BITS+1:2];  // byte address to word index.

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[word] <= write_data;
    end
  end

  assign read_data = mem[word];

endmodule

`default_nettype wire

// File: source/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
  input  logic              clk,
  input  logic              rst_n,
  output cpu_pkg::pc_t      imem_addr,
  input  cpu_pkg::inst_t    imem_data,
  output logic              wb_en,
  output cpu_pkg::reg_idx_t wb_reg,
  output cpu_pkg::data_t    wb_data
);

  cpu_pkg::pc_t      pc, pc_plus4;
  logic              stall, flush;
  cpu_pkg::inst_t    id_inst;
  cpu_pkg::pc_t      id_pc_plus4, id_jump_target, id_target;
  cpu_pkg::reg_idx_t id_rs, id_rt, id_rd, hz_id_rs, hz_id_rt;
  cpu_pkg::data_t    id_imm, id_read_1, id_read_2;
  logic              id_reg_dst, id_alu_src, id_reg_write, id_beq, id_bne, id_jump;
  cpu_pkg::alu_op_t  id_alu_op;
  cpu_pkg::mem_op_t  id_mem_op;
  cpu_pkg::reg_idx_t ex_rs, ex_rt, ex_rd, ex_dst;
  cpu_pkg::data_t    ex_read_1, ex_read_2, ex_imm, ex_a, ex_b, ex_store, ex_result;
  cpu_pkg::pc_t      ex_target;
  logic              ex_reg_dst, ex_alu_src, ex_reg_write, ex_beq, ex_bne, ex_jump;
  logic              ex_equal, ex_load;
  cpu_pkg::alu_op_t  ex_alu_op;
  cpu_pkg::mem_op_t  ex_mem_op;
  cpu_pkg::fwd_sel_t fwd_a, fwd_b;
  cpu_pkg::data_t    mem_alu_result, mem_store_data, mem_read_data;
  cpu_pkg::pc_t      mem_target;
  cpu_pkg::reg_idx_t mem_dst;
  logic              mem_reg_write, mem_redirect;
  cpu_pkg::mem_op_t  mem_op;

  // -------------------- fetch
  assign imem_addr = pc;
  assign pc_plus4  = pc + 32'd4;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (mem_redirect) begin
      pc <= mem_target;
    end else if (!stall) begin
      pc <= pc_plus4;
    end
  end

  if_id_register if_id_i (
    .clk, .rst_n, .stall, .flush,
    .inst_in(imem_data), .pc_plus4_in(pc_plus4),
    .inst_out(id_inst), .pc_plus4_out(id_pc_plus4)
  );

  // -------------------- decode
  control_decoder decoder_i (
    .inst(id_inst), .rs(id_rs), .rt(id_rt), .rd(id_rd), .immediate(id_imm),
    .target(id_jump_target), .reg_dst(id_reg_dst), .alu_src(id_alu_src),
    .reg_write(id_reg_write), .beq(id_beq), .bne(id_bne), .jump(id_jump),
    .alu_op(id_alu_op), .mem_op(id_mem_op)
  );

  reg_file reg_file_i (
    .clk, .rst_n, .read_reg_1(id_rs), .read_reg_2(id_rt),
    .write_reg(wb_reg), .write_en(wb_en), .write_data(wb_data),
    .read_data_1(id_read_1), .read_data_2(id_read_2)
  );

  assign id_target = id_jump ? id_jump_target : id_pc_plus4 + {id_imm[29:0], 2'b00};

  // only fields that are really read can cause a load-use stall.
  assign hz_id_rs = id_jump ? '0 : id_rs;
  assign hz_id_rt = ((!id_alu_src && !id_jump) || id_mem_op == cpu_pkg::MEM_STORE) ? id_rt : '0;

  id_ex_register id_ex_i (
    .clk, .rst_n, .stall, .flush,
    .rs_in(id_rs), .rt_in(id_rt), .rd_in(id_rd),
    .read_data_1_in(id_read_1), .read_data_2_in(id_read_2), .immediate_in(id_imm),
    .target_in(id_target), .reg_dst_in(id_reg_dst), .alu_src_in(id_alu_src),
    .reg_write_in(id_reg_write), .beq_in(id_beq), .bne_in(id_bne), .jump_in(id_jump),
    .alu_op_in(id_alu_op), .mem_op_in(id_mem_op),
    .rs_out(ex_rs), .rt_out(ex_rt), .rd_out(ex_rd),
    .read_data_1_out(ex_read_1), .read_data_2_out(ex_read_2), .immediate_out(ex_imm),
    .target_out(ex_target), .reg_dst_out(ex_reg_dst), .alu_src_out(ex_alu_src),
    .reg_write_out(ex_reg_write), .beq_out(ex_beq), .bne_out(ex_bne), .jump_out(ex_jump),
    .alu_op_out(ex_alu_op), .mem_op_out(ex_mem_op)
  );

  // -------------------- execute
  assign ex_load = (ex_mem_op == cpu_pkg::MEM_LOAD) && ex_reg_write;

  hazard_unit hazard_i (
    .id_rs(hz_id_rs), .id_rt(hz_id_rt), .ex_rs, .ex_rt, .mem_dst, .wb_dst(wb_reg),
    .mem_reg_write, .wb_reg_write(wb_en), .ex_load, .redirect(mem_redirect),
    .stall, .flush, .fwd_a, .fwd_b
  );

  function automatic cpu_pkg::data_t forward(input cpu_pkg::fwd_sel_t sel,
                                             input cpu_pkg::data_t reg_value);
    case (sel)
      cpu_pkg::FWD_MEM: return mem_alu_result;
      cpu_pkg::FWD_WB:  return wb_data;
      default:          return reg_value;
    endcase
  endfunction

  always_comb begin
    ex_a     = forward(fwd_a, ex_read_1);
    ex_store = forward(fwd_b, ex_read_2);  // also the store data.
  end

  assign ex_b   = ex_alu_src ? ex_imm : ex_store;
  assign ex_dst = ex_reg_dst ? ex_rd : ex_rt;

  alu alu_i (.op(ex_alu_op), .a(ex_a), .b(ex_b), .result(ex_result), .equal(ex_equal));

  ex_mem_register ex_mem_i (
    .clk, .rst_n, .flush,
    .alu_result_in(ex_result), .store_data_in(ex_store), .target_in(ex_target),
    .dst_reg_in(ex_dst), .compare_in(ex_equal), .beq_in(ex_beq), .bne_in(ex_bne),
    .jump_in(ex_jump), .reg_write_in(ex_reg_write), .mem_op_in(ex_mem_op),
    .alu_result_out(mem_alu_result), .store_data_out(mem_store_data),
    .target_out(mem_target), .dst_reg_out(mem_dst), .compare_out(), .beq_out(),
    .bne_out(), .jump_out(), .reg_write_out(mem_reg_write), .mem_op_out(mem_op),
    .redirect(mem_redirect)
  );

  // -------------------- memory, write-back
  data_ram data_ram_i (
    .clk, .addr(mem_alu_result), .write_en(mem_op == cpu_pkg::MEM_STORE),
    .write_data(mem_store_data), .read_data(mem_read_data)
  );

  mem_wb_register mem_wb_i (
    .clk, .rst_n,
    .mem_to_reg_in(mem_op == cpu_pkg::MEM_LOAD), .reg_write_in(mem_reg_write),
    .ram_read_data_in(mem_read_data), .alu_result_in(mem_alu_result), .dst_reg_in(mem_dst),
    .mem_to_reg_out(), .reg_write_out(wb_en), .ram_read_data_out(), .alu_result_out(),
    .dst_reg_out(wb_reg), .write_data(wb_data)
  );

endmodule

`default_nettype wire

// File: bench/cpu_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb;

  logic              clk;
  logic              rst_n;
  cpu_pkg::pc_t      imem_addr;
  cpu_pkg::inst_t    imem_data;
  logic              wb_en;
  cpu_pkg::reg_idx_t wb_reg;
  cpu_pkg::data_t    wb_data;

  cpu_pkg::inst_t rom [64];
  int             test_of [64];
  int             exp_reg [64], exp_cyc [64], exp_test [64];
  cpu_pkg::data_t exp_val [64];
  string          names [1:6];
  int n_prog, n_exp, wb_idx, cyc, errors, reported, reported_errors;
  logic rst_seen;

  cpu_core cpu_core_i (.clk, .rst_n, .imem_addr, .imem_data, .wb_en, .wb_reg, .wb_data);

  assign imem_data = rom[imem_addr[7:2]];  // combinational rom.

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    rst_seen <= 1'b1;
    cyc      <= rst_n ? cyc + 1 : 0;
    if (rst_n && wb_en) wb_idx <= wb_idx + 1;
  end

  // -------------------- checks
  // fetch starts at address 0.
  a_fetch_reset: assert property (@(posedge clk) (rst_seen && !rst_n) |-> imem_addr == '0)
    else begin
      errors++;
      $display("mismatch imem_addr %h expected %h", $sampled(imem_addr), 32'h0);
    end
  a_reset_quiet: assert property (@(posedge clk) (rst_seen && (!rst_n || cyc < 4)) |-> !wb_en)
    else begin
      errors++;
      $display("wb_en went high during reset or just after it.");
    end
  a_write_value: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_en && wb_idx < n_exp) |-> (wb_reg == exp_reg[wb_idx] && wb_data == exp_val[wb_idx]))
    else begin
      errors++;
      $display("mismatch wb_reg %h expected %h, wb_data %h expected %h", $sampled(wb_reg),
               exp_reg[$sampled(wb_idx)], $sampled(wb_data), exp_val[$sampled(wb_idx)]);
    end
  a_write_time: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_en && wb_idx < n_exp) |-> cyc == exp_cyc[wb_idx])
    else begin
      errors++;
      $display("write %0d came in cycle %0d instead of cycle %0d", $sampled(wb_idx),
               $sampled(cyc), exp_cyc[$sampled(wb_idx)]);
    end
  a_no_extra: assert property (@(posedge clk) disable iff (!rst_n) wb_en |-> wb_idx < n_exp)
    else begin
      errors++;
      $display("a register write came after the last expected one.");
    end

  // -------------------- program and model
  function automatic cpu_pkg::inst_t r_type(logic [5:0] fn, int rd, int rs, int rt);
    return {cpu_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
  endfunction

  function automatic cpu_pkg::inst_t i_type(logic [5:0] op, int rt, int rs, logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  task automatic emit(cpu_pkg::inst_t word, int test);
    rom[n_prog]     = word;
    test_of[n_prog] = test;
    n_prog++;
  endtask

  task automatic build_program();
    for (int i = 0; i < 64; i++) rom[i] = cpu_pkg::NOP_INST;
    emit(i_type(cpu_pkg::OP_ADDI, 1, 0, 16'($urandom)), 2);  // random arithmetic block.
    emit(i_type(cpu_pkg::OP_ADDI, 2, 1, 16'($urandom)), 2);
    emit(r_type(cpu_pkg::FN_ADD, 3, 2, 1), 2);
    emit(r_type(cpu_pkg::FN_SUB, 4, 3, 2), 2);
    emit(r_type(cpu_pkg::FN_AND, 5, 4, 3), 2);
    emit(r_type(cpu_pkg::FN_OR, 6, 5, 4), 2);
    emit(r_type(cpu_pkg::FN_SLT, 7, 6, 5), 2);
    emit(r_type(cpu_pkg::FN_SLT, 8, 5, 6), 2);
    emit(i_type(cpu_pkg::OP_ADDI, 9, 0, 16'h0040), 3);
    emit(i_type(cpu_pkg::OP_SW, 3, 9, 16'h0000), 3);
    emit(i_type(cpu_pkg::OP_LW, 10, 9, 16'h0000), 3);
    emit(r_type(cpu_pkg::FN_ADD, 11, 10, 1), 3);  // load-use on rs.
    emit(i_type(cpu_pkg::OP_SW, 4, 9, 16'h0004), 3);
    emit(i_type(cpu_pkg::OP_LW, 12, 9, 16'h0004), 3);
    emit(i_type(cpu_pkg::OP_ADDI, 13, 12, 16'h0001), 3);
    emit(i_type(cpu_pkg::OP_ADDI, 14, 0, 16'h0005), 4);
    emit(i_type(cpu_pkg::OP_BEQ, 14, 14, 16'h0003), 4);  // taken.
    for (int i = 0; i < 3; i++) emit(i_type(cpu_pkg::OP_ADDI, 15, 0, 16'(i + 1)), 4);
    emit(i_type(cpu_pkg::OP_ADDI, 16, 0, 16'h0001), 4);
    emit(i_type(cpu_pkg::OP_BNE, 0, 14, 16'h0003), 4);  // taken.
    for (int i = 0; i < 3; i++) emit(i_type(cpu_pkg::OP_ADDI, 15, 0, 16'(i + 4)), 4);
    emit(i_type(cpu_pkg::OP_BEQ, 0, 14, 16'h0003), 4);  // not taken.
    for (int i = 0; i < 3; i++) emit(i_type(cpu_pkg::OP_ADDI, 17 + i, 14, 16'(i)), 4);
    emit({cpu_pkg::OP_J, 26'(n_prog + 4)}, 5);
    for (int i = 0; i < 3; i++) emit(i_type(cpu_pkg::OP_ADDI, 15, 0, 16'(i + 7)), 5);
    emit(i_type(cpu_pkg::OP_ADDI, 20, 0, 16'h0007), 5);
    emit(i_type(cpu_pkg::OP_ADDI, 0, 0, 16'h007b), 6);
    emit(r_type(cpu_pkg::FN_OR, 21, 0, 20), 6);
    emit({cpu_pkg::OP_J, 26'(n_prog)}, 6);  // halt loop.
  endtask

  task automatic run_model();
    cpu_pkg::data_t regs [32], dmem [256];
    cpu_pkg::data_t a, b, imm, res;
    cpu_pkg::inst_t inst;
    logic [5:0] op;
    int pc, issue, load_rt, rs, rt, next, gap, dst;
    logic rt_used;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    pc = 0;
    issue = 0;
    load_rt = 0;
    for (int step = 0; step < 200; step++) begin
      inst = rom[pc];
      op = inst[31:26];
      rs = inst[25:21];
      rt = inst[20:16];
      a = regs[rs];
      b = regs[rt];
      imm = {{16{inst[15]}}, inst[15:0]};
      rt_used = op inside {cpu_pkg::OP_RTYPE, cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE, cpu_pkg::OP_SW};
      if (load_rt != 0 && ((op != cpu_pkg::OP_J && rs == load_rt) || (rt_used && rt == load_rt)))
        issue++;  // one stall cycle.
      if (op == cpu_pkg::OP_J && int'(inst[25:0]) == pc) break;
      next = pc + 1;
      gap = 1;
      dst = 0;
      load_rt = 0;
      case (op)
        cpu_pkg::OP_RTYPE: begin
          dst = inst[15:11];
          case (inst[5:0])
            cpu_pkg::FN_ADD: res = a + b;
            cpu_pkg::FN_SUB: res = a - b;
            cpu_pkg::FN_AND: res = a & b;
            cpu_pkg::FN_OR:  res = a | b;
            cpu_pkg::FN_SLT: res = (signed'(a) < signed'(b)) ? 32'd1 : 32'd0;
            default:         dst = 0;  // unknown funct writes nothing.
          endcase
        end
        cpu_pkg::OP_ADDI: begin
          dst = rt;
          res = a + imm;
        end
        cpu_pkg::OP_LW: begin
          dst = rt;
          res = dmem[(a + imm) >> 2 & 255];
          load_rt = rt;
        end
        cpu_pkg::OP_SW: dmem[(a + imm) >> 2 & 255] = b;
        cpu_pkg::OP_BEQ: begin
          if (a == b) begin
            next = pc + 1 + int'(imm);
            gap = 4;
          end
        end
        cpu_pkg::OP_BNE: begin
          if (a != b) begin
            next = pc + 1 + int'(imm);
            gap = 4;
          end
        end
        cpu_pkg::OP_J: begin
          next = inst[25:0];
          gap = 4;
        end
        default: ;
      endcase
      if (dst != 0) begin
        regs[dst] = res;
        exp_reg[n_exp]  = dst;
        exp_val[n_exp]  = res;
        exp_cyc[n_exp]  = issue + 4;
        exp_test[n_exp] = test_of[pc];
        n_exp++;
      end
      pc = next;
      issue += gap;
    end
  endtask

  // -------------------- reporting
  always @(negedge clk) begin
    if (rst_n && cyc == 4) begin
      $display("test 1 %s: done, %0d errors", names[1], errors);
      reported_errors = errors;
    end
    if (rst_n && wb_idx > reported &&
        (wb_idx == n_exp || exp_test[wb_idx] != exp_test[wb_idx - 1])) begin
      $display("test %0d %s: done, %0d errors", exp_test[wb_idx - 1],
               names[exp_test[wb_idx - 1]], errors - reported_errors);
      reported = wb_idx;
      reported_errors = errors;
    end
  end

  initial begin
    int limit;
    names = '{"reset", "arithmetic", "load and store", "branches", "jump", "register 0"};
    rst_n = 1'b0;
    {n_prog, n_exp, wb_idx, cyc, errors, reported, reported_errors} = '0;
    rst_seen = 1'b0;
    void'($urandom(32'hefc0_8e05));
    build_program();
    run_model();
    limit = n_prog * 20 + 50;
    fork
      begin
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, %0d of %0d writes seen", limit, wb_idx, n_exp);
        $display("CHECKS FAILED");
        $finish;
      end
    join_none
    repeat (8) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;
    while (wb_idx < n_exp) @(negedge clk);
    repeat (12) @(negedge clk);  // the halt loop must stay silent.
    $display("writes %0d of %0d, errors %0d", wb_idx, n_exp, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
source/cpu_pkg.sv
source/pipeline_regs.sv
source/control_decoder.sv
source/reg_file.sv
source/alu.sv
source/hazard_unit.sv
source/data_ram.sv
source/cpu_core.sv
bench/cpu_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -j 0
TOP       ?= cpu_core_tb
FILELIST  ?= all.f
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
